// File: list.f
verilog/axil_pkg.sv
verilog/fetch_port.sv
verilog/load_store_port.sv
verilog/axil_arbiter.sv
verilog/axil_sram.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the memory subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_subsys \
	-f list.f -o tb_mem_subsys > build.log 2>&1 \
	&& ./obj_dir/tb_mem_subsys > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qx "TESTS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys import axil_pkg::*; ();
	localparam int MEM_WORDS = 256;
	localparam int MEM_LATENCY = 2;
	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int TEST_WORDS = 16; // words that hold known data after the first test.
	localparam int MAX_TXNS = 150;
	localparam int TXN_CYCLES = 12;
	localparam int CYCLE_LIMIT = MAX_TXNS * TXN_CYCLES + 200;

	logic clk;
	logic rst;
	logic fetch_req;
	addr_t fetch_addr;
	logic fetch_ready;
	logic fetch_done;
	data_t fetch_data;
	logic fetch_err;
	logic ls_req;
	logic ls_write;
	addr_t ls_addr;
	data_t ls_wdata;
	strb_t ls_wstrb;
	logic ls_ready;
	logic ls_done;
	logic ls_err;
	data_t ls_rdata;

	data_t model [MEM_WORDS];
	logic [31:0] lfsr;
	int cycles = 0;
	int value_errs;
	int other_errs;

	mem_subsys_top #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_dut (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois form.
	endfunction

	// one lfsr step per bit taken.
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic addr_ok(addr_t a);
		return a < addr_t'(4 * MEM_WORDS);
	endfunction

	function automatic data_t fill_word(addr_t a);
		return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1 ^ (a * 32'd2654435761);
	endfunction

	function automatic data_t model_read(addr_t a);
		return addr_ok(a) ? model[a[IDX_W+1:2]] : '0;
	endfunction

	task automatic model_write(addr_t a, data_t d, strb_t s);
		if (addr_ok(a)) begin
			for (int i = 0; i < 4; i++) begin
				if (s[i]) begin
					model[a[IDX_W+1:2]][8*i +: 8] = d[8*i +: 8];
				end
			end
		end
	endtask

	// mostly the known words, now and then an aliasing address out of range.
	function automatic addr_t random_addr();
		logic [31:0] idx;
		logic [31:0] far;
		idx = rand_bits(4);
		far = rand_bits(3);
		return (far == 0) ? (32'h400 + (idx << 2)) : (idx << 2);
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(string what);
		other_errs++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic ls_access(logic write, addr_t a, data_t d, strb_t s);
		data_t exp;
		exp = write ? '0 : model_read(a);
		while (!ls_ready) @(negedge clk);
		ls_req = 1'b1;
		ls_write = write;
		ls_addr = a;
		ls_wdata = d;
		ls_wstrb = s;
		@(negedge clk);
		ls_req = 1'b0;
		check_value("ls_ready", 32'(ls_ready), 32'd0); // busy once the request is taken.
		while (!ls_done) @(negedge clk);
		check_value("ls_ready", 32'(ls_ready), 32'd1);
		check_value("ls_err", 32'(ls_err), 32'(!addr_ok(a)));
		if (write || addr_ok(a)) begin
			check_value("ls_rdata", ls_rdata, exp);
		end
		if (write) begin
			model_write(a, d, s);
		end
	endtask

	task automatic fetch_access(addr_t a);
		while (!fetch_ready) @(negedge clk);
		fetch_req = 1'b1;
		fetch_addr = a;
		@(negedge clk);
		fetch_req = 1'b0;
		check_value("fetch_ready", 32'(fetch_ready), 32'd0);
		while (!fetch_done) @(negedge clk);
		check_value("fetch_ready", 32'(fetch_ready), 32'd1);
		check_value("fetch_err", 32'(fetch_err), 32'(!addr_ok(a)));
		if (addr_ok(a)) begin
			check_value("fetch_data", fetch_data, model_read(a));
		end
	endtask

	// both ports ask in the same cycle.
	task automatic pair_access(addr_t fa, logic write, addr_t a, data_t d, strb_t s);
		data_t f_exp;
		data_t l_exp;
		int f_at;
		int l_at;
		f_exp = model_read(fa); // fetch wins the tie and reads first.
		l_exp = write ? '0 : model_read(a);
		f_at = -1;
		l_at = -1;
		while (!(fetch_ready && ls_ready)) @(negedge clk);
		fetch_req = 1'b1;
		fetch_addr = fa;
		ls_req = 1'b1;
		ls_write = write;
		ls_addr = a;
		ls_wdata = d;
		ls_wstrb = s;
		@(negedge clk);
		fetch_req = 1'b0;
		ls_req = 1'b0;
		check_value("fetch_ready", 32'(fetch_ready), 32'd0);
		check_value("ls_ready", 32'(ls_ready), 32'd0);
		while (f_at < 0 || l_at < 0) begin
			if (fetch_done && f_at < 0) begin
				f_at = cycles;
				check_value("fetch_err", 32'(fetch_err), 32'(!addr_ok(fa)));
				if (addr_ok(fa)) begin
					check_value("fetch_data", fetch_data, f_exp);
				end
			end
			if (ls_done && l_at < 0) begin
				l_at = cycles;
				check_value("ls_err", 32'(ls_err), 32'(!addr_ok(a)));
				if (write || addr_ok(a)) begin
					check_value("ls_rdata", ls_rdata, l_exp);
				end
			end
			@(negedge clk);
		end
		if (f_at >= l_at) begin
			note_failure("fetch_done did not come before ls_done on a same-cycle request");
		end
		if (write) begin
			model_write(a, d, s);
		end
	endtask

	task automatic test_full_words();
		for (int i = 0; i < TEST_WORDS; i++) begin
			ls_access(1'b1, addr_t'(4 * i), fill_word(addr_t'(4 * i)), 4'hf);
		end
		for (int i = 0; i < TEST_WORDS; i++) begin
			ls_access(1'b0, addr_t'(4 * i), '0, 4'h0);
		end
	endtask

	task automatic test_partial_strobes();
		ls_access(1'b1, 32'h50, 32'h1122_3344, 4'hf);
		ls_access(1'b1, 32'h50, 32'haabb_ccdd, 4'b0001);
		ls_access(1'b0, 32'h50, '0, 4'h0);
		ls_access(1'b1, 32'h50, 32'h5566_7788, 4'b0110);
		ls_access(1'b0, 32'h50, '0, 4'h0);
		ls_access(1'b1, 32'h50, 32'hf0e1_d2c3, 4'b1000);
		ls_access(1'b0, 32'h50, '0, 4'h0);
	endtask

	task automatic test_fetch_written();
		for (int i = 0; i < 8; i++) begin
			fetch_access(addr_t'(4 * i));
		end
	endtask

	task automatic test_out_of_range();
		ls_access(1'b0, 32'h400, '0, 4'h0);
		ls_access(1'b1, 32'h40c, 32'hdead_beef, 4'hf); // aliases word 3.
		ls_access(1'b1, 32'hffff_fffc, 32'h0bad_f00d, 4'hf);
		fetch_access(32'h8000_0010);
		ls_access(1'b0, 32'hc, '0, 4'h0);
	endtask

	task automatic test_same_cycle();
		pair_access(32'h8, 1'b0, 32'h14, '0, 4'h0);
		pair_access(32'h1c, 1'b1, 32'h1c, 32'h7654_3210, 4'hf);
		ls_access(1'b0, 32'h1c, '0, 4'h0);
	endtask

	task automatic random_mix(int count);
		logic [1:0] op;
		addr_t a;
		addr_t fa;
		data_t d;
		strb_t s;
		logic write;
		for (int n = 0; n < count; n++) begin
			op = 2'(rand_bits(2));
			a = random_addr();
			fa = random_addr();
			d = rand_bits(32);
			s = 4'(rand_bits(4));
			write = rand_bits(1) != 0;
			case (op)
				2'd0: ls_access(1'b0, a, '0, 4'h0);
				2'd1: ls_access(1'b1, a, d, s);
				2'd2: fetch_access(fa);
				default: pair_access(fa, write, a, d, s);
			endcase
		end
	endtask

	initial begin
		lfsr = 32'ha7a7;
		value_errs = 0;
		other_errs = 0;
		rst = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		ls_req = 1'b0;
		ls_write = 1'b0;
		ls_addr = '0;
		ls_wdata = '0;
		ls_wstrb = '0;
		repeat (4) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		test_full_words();
		test_partial_strobes();
		test_fetch_written();
		test_out_of_range();
		test_same_cycle();
		random_mix(100);

		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/axil_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axil_arbiter import axil_pkg::*; (
	input logic clk,
	input logic rst,
	// fetch master.
	input axil_ar_t f_ar,
	input logic f_arvalid,
	output logic f_arready,
	input axil_aw_t f_aw,
	input logic f_awvalid,
	output logic f_awready,
	input axil_w_t f_w,
	input logic f_wvalid,
	output logic f_wready,
	output axil_r_t f_r,
	output logic f_rvalid,
	input logic f_rready,
	output axil_b_t f_b,
	output logic f_bvalid,
	input logic f_bready,
	// load/store master.
	input axil_ar_t l_ar,
	input logic l_arvalid,
	output logic l_arready,
	input axil_aw_t l_aw,
	input logic l_awvalid,
	output logic l_awready,
	input axil_w_t l_w,
	input logic l_wvalid,
	output logic l_wready,
	output axil_r_t l_r,
	output logic l_rvalid,
	input logic l_rready,
	output axil_b_t l_b,
	output logic l_bvalid,
	input logic l_bready,
	// slave.
	output axil_ar_t s_ar,
	output logic s_arvalid,
	input logic s_arready,
	output axil_aw_t s_aw,
	output logic s_awvalid,
	input logic s_awready,
	output axil_w_t s_w,
	output logic s_wvalid,
	input logic s_wready,
	input axil_r_t s_r,
	input logic s_rvalid,
	output logic s_rready,
	input axil_b_t s_b,
	input logic s_bvalid,
	output logic s_bready
);
	arb_state_e state;
	logic f_trig;
	logic l_trig;
	logic f_gnt;
	logic l_gnt;
	logic owner_done;

	assign f_trig = f_arvalid || (f_awvalid && f_wvalid);
	assign l_trig = l_arvalid || (l_awvalid && l_wvalid);
	assign f_gnt = (state == ARB_FETCH);
	assign l_gnt = (state == ARB_LS);
	// only the owner can drive the slave readies, so this is its completion.
	assign owner_done = (s_rvalid && s_rready) || (s_bvalid && s_bready);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (f_trig) begin
						state <= ARB_FETCH; // fetch wins a tie.
					end else if (l_trig) begin
						state <= ARB_LS;
					end
				end
				ARB_FETCH, ARB_LS: begin
					if (owner_done) begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// owner to slave.
	assign s_ar = l_gnt ? l_ar : f_ar;
	assign s_aw = l_gnt ? l_aw : f_aw;
	assign s_w = l_gnt ? l_w : f_w;
	assign s_arvalid = (f_gnt && f_arvalid) || (l_gnt && l_arvalid);
	assign s_awvalid = (f_gnt && f_awvalid) || (l_gnt && l_awvalid);
	assign s_wvalid = (f_gnt && f_wvalid) || (l_gnt && l_wvalid);
	assign s_rready = (f_gnt && f_rready) || (l_gnt && l_rready);
	assign s_bready = (f_gnt && f_bready) || (l_gnt && l_bready);

	// slave back to the owner only.
	assign f_arready = f_gnt && s_arready;
	assign f_awready = f_gnt && s_awready;
	assign f_wready = f_gnt && s_wready;
	assign f_r = f_gnt ? s_r : '0;
	assign f_rvalid = f_gnt && s_rvalid;
	assign f_b = f_gnt ? s_b : '0;
	assign f_bvalid = f_gnt && s_bvalid;

	assign l_arready = l_gnt && s_arready;
	assign l_awready = l_gnt && s_awready;
	assign l_wready = l_gnt && s_wready;
	assign l_r = l_gnt ? s_r : '0;
	assign l_rvalid = l_gnt && s_rvalid;
	assign l_b = l_gnt ? s_b : '0;
	assign l_bvalid = l_gnt && s_bvalid;

	// a grant always passes through idle.
	assert property (@(posedge clk) disable iff (!rst) state == ARB_FETCH |=> state != ARB_LS);

endmodule

`default_nettype wire

// File: verilog/axil_pkg.sv
`default_nettype none

package axil_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	typedef struct packed {
		addr_t addr;
	} axil_ar_t;

	typedef struct packed {
		addr_t addr;
	} axil_aw_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} axil_w_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} axil_r_t;

	typedef struct packed {
		resp_t resp;
	} axil_b_t;

	typedef enum logic [1:0] {ARB_IDLE, ARB_FETCH, ARB_LS} arb_state_e;
	typedef enum logic [1:0] {PORT_IDLE, PORT_ADDR, PORT_WAIT} port_state_e;

endpackage

`default_nettype wire

// File: verilog/axil_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axil_sram import axil_pkg::*; #(
	parameter int MEM_WORDS = 256,
	parameter int MEM_LATENCY = 2
) (
	input logic clk,
	input logic rst,
	input axil_ar_t ar,
	input logic arvalid,
	output logic arready,
	input axil_aw_t aw,
	input logic awvalid,
	output logic awready,
	input axil_w_t w,
	input logic wvalid,
	output logic wready,
	output axil_r_t r,
	output logic rvalid,
	input logic rready,
	output axil_b_t b,
	output logic bvalid,
	input logic bready
);
	localparam int IDX_W = $clog2(MEM_WORDS);

	data_t mem [MEM_WORDS];
	logic busy;
	logic is_write;
	logic [2:0] cnt;
	data_t rdata_q;
	resp_t resp_q;
	logic rd_acc;
	logic wr_acc;
	logic rsp_done;
	addr_t acc_addr;
	logic in_range;
	logic [IDX_W-1:0] idx;

	assign arready = !busy;
	assign awready = !busy && awvalid && wvalid && !arvalid; // reads win a clash.
	assign wready = awready;

	assign rd_acc = arvalid && arready;
	assign wr_acc = awvalid && awready && wvalid && wready;
	assign rsp_done = (rvalid && rready) || (bvalid && bready);

	assign acc_addr = rd_acc ? ar.addr : aw.addr;
	assign in_range = (acc_addr >> 2) < addr_t'(MEM_WORDS);
	assign idx = acc_addr[IDX_W+1:2];

	assign r = '{data: rdata_q, resp: resp_q};
	assign b = '{resp: resp_q};

	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			cnt <= '0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else if (rd_acc || wr_acc) begin
			busy <= 1'b1;
			cnt <= 3'(MEM_LATENCY - 1);
		end else if (busy && !rvalid && !bvalid) begin
			if (cnt == 3'd0) begin
				rvalid <= !is_write;
				bvalid <= is_write;
			end else begin
				cnt <= cnt - 3'd1;
			end
		end else if (rsp_done) begin
			busy <= 1'b0;
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_acc || wr_acc) begin
			is_write <= wr_acc;
			resp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
			rdata_q <= in_range ? mem[idx] : '0;
		end
		if (wr_acc && in_range) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i]) begin
					mem[idx][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst) !(rvalid && bvalid));

endmodule

`default_nettype wire

// File: verilog/fetch_port.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_port import axil_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input addr_t fetch_addr,
	output logic fetch_ready,
	output logic fetch_done,
	output data_t fetch_data,
	output logic fetch_err,
	output axil_ar_t ar,
	output logic arvalid,
	input logic arready,
	input axil_r_t r,
	input logic rvalid,
	output logic rready,
	output axil_aw_t aw,
	output logic awvalid,
	input logic awready,
	output axil_w_t w,
	output logic wvalid,
	input logic wready,
	input axil_b_t b,
	input logic bvalid,
	output logic bready
);
	port_state_e state;
	addr_t addr_q;

	assign fetch_ready = (state == PORT_IDLE);
	assign arvalid = (state == PORT_ADDR);
	assign ar = '{addr: addr_q};
	assign rready = (state == PORT_WAIT); // never refuse a response.

	// read only master.
	assign aw = '0;
	assign awvalid = 1'b0;
	assign w = '0;
	assign wvalid = 1'b0;
	assign bready = 1'b0;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= PORT_IDLE;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				PORT_IDLE: begin
					if (fetch_req) begin
						state <= PORT_ADDR;
					end
				end
				PORT_ADDR: begin
					if (arready) begin
						state <= PORT_WAIT;
					end
				end
				PORT_WAIT: begin
					if (rvalid) begin
						state <= PORT_IDLE;
						fetch_done <= 1'b1;
					end
				end
				default: state <= PORT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_ready && fetch_req) begin
			addr_q <= fetch_addr;
		end
		if (rvalid && rready) begin
			fetch_data <= r.data;
			fetch_err <= (r.resp != RESP_OKAY);
		end
	end

	// held off by the arbiter, the request must wait unchanged.
	assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(ar));

endmodule

`default_nettype wire

// File: verilog/load_store_port.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_port import axil_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ls_req,
	input logic ls_write,
	input addr_t ls_addr,
	input data_t ls_wdata,
	input strb_t ls_wstrb,
	output logic ls_ready,
	output logic ls_done,
	output logic ls_err,
	output data_t ls_rdata,
	output axil_ar_t ar,
	output logic arvalid,
	input logic arready,
	output axil_aw_t aw,
	output logic awvalid,
	input logic awready,
	output axil_w_t w,
	output logic wvalid,
	input logic wready,
	input axil_r_t r,
	input logic rvalid,
	output logic rready,
	input axil_b_t b,
	input logic bvalid,
	output logic bready
);
	port_state_e state;
	logic write_q;
	addr_t addr_q;
	data_t wdata_q;
	strb_t wstrb_q;
	logic addr_hs;
	logic resp_hs;

	assign ls_ready = (state == PORT_IDLE);

	assign arvalid = (state == PORT_ADDR) && !write_q;
	assign awvalid = (state == PORT_ADDR) && write_q;
	assign wvalid = awvalid; // address and data go out as one event.
	assign ar = '{addr: addr_q};
	assign aw = '{addr: addr_q};
	assign w = '{data: wdata_q, strb: wstrb_q};

	assign rready = (state == PORT_WAIT) && !write_q;
	assign bready = (state == PORT_WAIT) && write_q;

	assign addr_hs = write_q ? (awvalid && awready && wvalid && wready) : (arvalid && arready);
	assign resp_hs = (rvalid && rready) || (bvalid && bready);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= PORT_IDLE;
			ls_done <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			case (state)
				PORT_IDLE: begin
					if (ls_req) begin
						state <= PORT_ADDR;
					end
				end
				PORT_ADDR: begin
					if (addr_hs) begin
						state <= PORT_WAIT;
					end
				end
				PORT_WAIT: begin
					if (resp_hs) begin
						state <= PORT_IDLE;
						ls_done <= 1'b1;
					end
				end
				default: state <= PORT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ls_ready && ls_req) begin
			write_q <= ls_write;
			addr_q <= ls_addr;
			wdata_q <= ls_wdata;
			wstrb_q <= ls_wstrb;
		end
		if (resp_hs) begin
			ls_rdata <= write_q ? '0 : r.data; // stores return zero.
			ls_err <= write_q ? (b.resp != RESP_OKAY) : (r.resp != RESP_OKAY);
		end
	end

	// address and data are accepted on the same edge.
	assert property (@(posedge clk) disable iff (!rst)
		(awvalid && awready) == (wvalid && wready));

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top import axil_pkg::*; #(
	parameter int MEM_WORDS = 256,
	parameter int MEM_LATENCY = 2
) (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input addr_t fetch_addr,
	output logic fetch_ready,
	output logic fetch_done,
	output data_t fetch_data,
	output logic fetch_err,
	input logic ls_req,
	input logic ls_write,
	input addr_t ls_addr,
	input data_t ls_wdata,
	input strb_t ls_wstrb,
	output logic ls_ready,
	output logic ls_done,
	output logic ls_err,
	output data_t ls_rdata
);
	// f_ fetch side, l_ load/store side, s_ slave side.
	axil_ar_t f_ar, l_ar, s_ar;
	axil_aw_t f_aw, l_aw, s_aw;
	axil_w_t f_w, l_w, s_w;
	axil_r_t f_r, l_r, s_r;
	axil_b_t f_b, l_b, s_b;
	logic f_arvalid, f_arready, f_awvalid, f_awready, f_wvalid, f_wready;
	logic f_rvalid, f_rready, f_bvalid, f_bready;
	logic l_arvalid, l_arready, l_awvalid, l_awready, l_wvalid, l_wready;
	logic l_rvalid, l_rready, l_bvalid, l_bready;
	logic s_arvalid, s_arready, s_awvalid, s_awready, s_wvalid, s_wready;
	logic s_rvalid, s_rready, s_bvalid, s_bready;

	fetch_port u_fetch (
		.clk(clk), .rst(rst),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_ready(fetch_ready),
		.fetch_done(fetch_done), .fetch_data(fetch_data), .fetch_err(fetch_err),
		.ar(f_ar), .arvalid(f_arvalid), .arready(f_arready),
		.aw(f_aw), .awvalid(f_awvalid), .awready(f_awready),
		.w(f_w), .wvalid(f_wvalid), .wready(f_wready),
		.r(f_r), .rvalid(f_rvalid), .rready(f_rready),
		.b(f_b), .bvalid(f_bvalid), .bready(f_bready)
	);

	load_store_port u_ls (
		.clk(clk), .rst(rst),
		.ls_req(ls_req), .ls_write(ls_write), .ls_addr(ls_addr),
		.ls_wdata(ls_wdata), .ls_wstrb(ls_wstrb), .ls_ready(ls_ready),
		.ls_done(ls_done), .ls_err(ls_err), .ls_rdata(ls_rdata),
		.ar(l_ar), .arvalid(l_arvalid), .arready(l_arready),
		.aw(l_aw), .awvalid(l_awvalid), .awready(l_awready),
		.w(l_w), .wvalid(l_wvalid), .wready(l_wready),
		.r(l_r), .rvalid(l_rvalid), .rready(l_rready),
		.b(l_b), .bvalid(l_bvalid), .bready(l_bready)
	);

	// port names match the wires above.
	axil_arbiter u_arb (.*);

	axil_sram #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_sram (
		.clk(clk), .rst(rst),
		.ar(s_ar), .arvalid(s_arvalid), .arready(s_arready),
		.aw(s_aw), .awvalid(s_awvalid), .awready(s_awready),
		.w(s_w), .wvalid(s_wvalid), .wready(s_wready),
		.r(s_r), .rvalid(s_rvalid), .rready(s_rready),
		.b(s_b), .bvalid(s_bvalid), .bready(s_bready)
	);

endmodule

`default_nettype wire
